// File: all.f
board_pkg.sv
key_sync.sv
slow_clk_gen.sv
vga_timing.sv
lab_top.sv
board_specific_top.sv
tb_board_specific_top.sv

// File: board_pkg.sv
package board_pkg;

    //----------------------------------------------------------------------
    // board resources

    localparam int w_key   = 2;
    localparam int w_led   = 6;
    localparam int w_color = 8;

    // on-board oscillator
    localparam int clk_mhz = 27;

    //----------------------------------------------------------------------
    // 640x480 video timing

    // horizontal, in pixels
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // vertical, in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    localparam int w_x = 10;
    localparam int w_y = 10;

    // one slow tick per second on the board clock
    localparam int slow_div_default = clk_mhz * 1_000_000;

    //----------------------------------------------------------------------
    // shared types

    typedef logic [w_key   - 1:0] key_t;
    typedef logic [w_led   - 1:0] led_t;
    typedef logic [w_color - 1:0] color_t;
    typedef logic [w_x     - 1:0] coord_t;

    typedef enum logic [1:0]
    {
        phase_active,
        phase_front,
        phase_sync,
        phase_back
    } scan_phase_t;

    typedef enum logic
    {
        mode_run,
        mode_pause
    } lab_mode_t;

endpackage

// File: board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
    import board_pkg::*;
#(
    parameter int slow_div = slow_div_default
)
(
    input  logic               clk,
    input  logic               i_rst,

    // active-low buttons and LEDs on the board
    input  logic [w_key - 1:0] i_key,
    output logic [w_led - 1:0] o_led,

    // raw video out
    output logic               o_hsync,
    output logic               o_vsync,
    output logic               o_de,
    output color_t             o_red,
    output color_t             o_green,
    output color_t             o_blue
);

    //----------------------------------------------------------------------
    // pins to lab keys and lab leds back to pins

    key_t   lab_key;
    led_t   lab_led;
    key_t   lab_press;

    logic   slow_tick;
    coord_t x;
    coord_t y;

    // key pins are active low and wired in reverse order
    for (genvar i = 0; i < w_key; i++)
    begin : g_key
        assign lab_key[i] = ~i_key[w_key - 1 - i];
    end

    // same for the leds
    for (genvar i = 0; i < w_led; i++)
    begin : g_led
        assign o_led[i] = ~lab_led[w_led - 1 - i];
    end

    //----------------------------------------------------------------------

    key_sync key_sync_inst
    (
        .clk         ( clk         ),
        .i_rst       ( i_rst       ),
        .i_key       ( lab_key     ),
        .o_level     (             ),
        .o_press     ( lab_press   )
    );

    slow_clk_gen
    #(
        .slow_div    ( slow_div    )
    )
    slow_clk_gen_inst
    (
        .clk         ( clk         ),
        .i_rst       ( i_rst       ),
        .o_slow_tick ( slow_tick   )
    );

    // stands in for the pll-driven pixel clock path on the board
    vga_timing vga_timing_inst
    (
        .clk         ( clk         ),
        .i_rst       ( i_rst       ),
        .o_x         ( x           ),
        .o_y         ( y           ),
        .o_de        ( o_de        ),
        .o_hsync     ( o_hsync     ),
        .o_vsync     ( o_vsync     )
    );

    lab_top lab_top_inst
    (
        .clk         ( clk         ),
        .i_rst       ( i_rst       ),
        .i_slow_tick ( slow_tick   ),
        .i_press     ( lab_press   ),
        .i_x         ( x           ),
        .i_y         ( y           ),
        .i_de        ( o_de        ),
        .o_led       ( lab_led     ),
        .o_red       ( o_red       ),
        .o_green     ( o_green     ),
        .o_blue      ( o_blue      )
    );

endmodule

// File: key_sync.sv
`timescale 1ns/1ps

module key_sync
    import board_pkg::*;
(
    input  logic clk,
    input  logic i_rst,
    input  key_t i_key,
    output key_t o_level,
    output key_t o_press
);

    key_t sync_1;
    key_t sync_2;
    key_t level_prev;

    // buttons are asynchronous to clk
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
        end
        else
        begin
            sync_1 <= i_key;
            sync_2 <= sync_1;
        end
    end

    // rising edge of the synchronized level, registered
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            level_prev <= '0;
            o_press    <= '0;
        end
        else
        begin
            level_prev <= sync_2;
            o_press    <= sync_2 & ~level_prev;
        end
    end

    assign o_level = sync_2;

endmodule

// File: lab_top.sv
`timescale 1ns/1ps

module lab_top
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    input  logic   i_slow_tick,
    input  key_t   i_press,

    input  coord_t i_x,
    input  coord_t i_y,
    input  logic   i_de,

    output led_t   o_led,
    output color_t o_red,
    output color_t o_green,
    output color_t o_blue
);

    //----------------------------------------------------------------------
    // run / pause state

    lab_mode_t mode;

    logic toggle_req;
    logic clear_req;
    logic count_en;

    // key 0 toggles the mode, key 1 clears the counter
    assign toggle_req = i_press[0];
    assign clear_req  = i_press[1];

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            mode <= mode_run;
        end
        else if (toggle_req)
        begin
            case (mode)
                mode_run:   mode <= mode_pause;
                mode_pause: mode <= mode_run;
                default:    mode <= mode_run;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // led counter

    led_t cnt;

    assign count_en = i_slow_tick && (mode == mode_run);

    // a clear wins over an increment in the same cycle
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            cnt <= '0;
        end
        else if (clear_req)
        begin
            cnt <= '0;
        end
        else if (count_en)
        begin
            // wraps at 64 on its own
            cnt <= cnt + 1'b1;
        end
    end

    assign o_led = cnt;

    //----------------------------------------------------------------------
    // colour pattern

    // combinational so colours line up with de from vga_timing
    always_comb
    begin
        if (i_de)
        begin
            o_red   = i_x[w_color - 1:0];
            o_green = i_y[w_color - 1:0];
            o_blue  = {cnt, 2'b00};
        end
        else
        begin
            o_red   = '0;
            o_green = '0;
            o_blue  = '0;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass is decided from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_board_specific_top \
    -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: slow_clk_gen.sv
`timescale 1ns/1ps

module slow_clk_gen
    import board_pkg::*;
#(
    parameter int slow_div = slow_div_default
)
(
    input  logic clk,
    input  logic i_rst,
    output logic o_slow_tick
);

    localparam int w_cnt = (slow_div > 1) ? $clog2(slow_div) : 1;

    logic [w_cnt - 1:0] cnt;

    // enable strobe instead of a divided clock, everything stays on clk
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            cnt         <= '0;
            o_slow_tick <= 1'b0;
        end
        else if (cnt == w_cnt'(slow_div - 1))
        begin
            cnt         <= '0;
            o_slow_tick <= 1'b1;
        end
        else
        begin
            cnt         <= cnt + 1'b1;
            o_slow_tick <= 1'b0;
        end
    end

endmodule

// File: tb_board_specific_top.sv
`timescale 1ns/1ps

module tb_board_specific_top
    import board_pkg::*;
();

    localparam int clk_period = 8;
    localparam int slow_div   = 20;
    localparam int hold_keys  = 10;
    // one frame of 420,000 cycles plus the counter tests, with margin
    localparam int max_cycles = 500_000;

    logic               clk;
    logic               i_rst;
    logic [w_key - 1:0] i_key;
    logic [w_led - 1:0] o_led;
    logic               o_hsync;
    logic               o_vsync;
    logic               o_de;
    color_t             o_red;
    color_t             o_green;
    color_t             o_blue;

    int mismatches;
    int other_errors;
    int cycle_cnt;

    board_specific_top
    #(
        .slow_div ( slow_div )
    )
    board_specific_top_inst
    (
        .clk      ( clk      ),
        .i_rst    ( i_rst    ),
        .i_key    ( i_key    ),
        .o_led    ( o_led    ),
        .o_hsync  ( o_hsync  ),
        .o_vsync  ( o_vsync  ),
        .o_de     ( o_de     ),
        .o_red    ( o_red    ),
        .o_green  ( o_green  ),
        .o_blue   ( o_blue   )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("error: run timed out after %0d cycles", max_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //----------------------------------------------------------------------
    // reference model of the board, indexed by cycles since reset release

    // led pins are active low and wired in reverse order
    function automatic led_t pins_to_led(input logic [w_led - 1:0] pins);
        led_t rev;
        rev = {<<{pins}};
        return ~rev;
    endfunction

    // a tick every slow_div cycles, the counter follows one edge later
    function automatic led_t exp_count(input int c);
        if (c < 1)
            return '0;
        return led_t'(((c - 1) / slow_div) % 64);
    endfunction

    function automatic logic exp_de(input int c);
        return ((c % h_total) < h_active) && (((c / h_total) % v_total) < v_active);
    endfunction

    function automatic logic exp_hsync(input int c);
        int x;
        x = c % h_total;
        return !((x >= h_active + h_front) && (x < h_active + h_front + h_sync));
    endfunction

    function automatic logic exp_vsync(input int c);
        int y;
        y = (c / h_total) % v_total;
        return !((y >= v_active + v_front) && (y < v_active + v_front + v_sync));
    endfunction

    //----------------------------------------------------------------------
    // compare tasks

    task automatic check_led(input led_t exp);
        led_t act;
        act = pins_to_led(o_led);
        if (act !== exp)
        begin
            $display("mismatch o_led: expected %h, got %h", exp, act);
            mismatches++;
        end
    endtask

    task automatic check_color(input color_t exp, input color_t act, input string name);
        if (act !== exp)
        begin
            $display("mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bit(input logic exp, input logic act, input string name);
        if (act !== exp)
        begin
            $display("mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    //----------------------------------------------------------------------
    // stimulus helpers

    // inputs change and outputs are sampled 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        i_rst = 1'b1;
        repeat (5) step();
        i_rst = 1'b0;
    endtask

    // lab key k sits on pin bit (w_key - 1 - k), active low
    task automatic press_key(input int lab_idx);
        i_key = ~(key_t'(1) << (w_key - 1 - lab_idx));
        repeat (hold_keys) step();
        i_key = '1;
    endtask

    task automatic wait_led_change(input led_t from_val, input int limit);
        int n;
        n = 0;
        while ((pins_to_led(o_led) == from_val) && (n < limit))
        begin
            step();
            n++;
        end
        if (n >= limit)
        begin
            $display("error: leds did not change within %0d cycles", limit);
            other_errors++;
        end
    endtask

    //----------------------------------------------------------------------
    // directed tests

    task automatic test_reset_state();
        check_led('0);
        check_bit(1'b1, o_hsync, "o_hsync");
        check_bit(1'b1, o_vsync, "o_vsync");
        check_bit(1'b1, o_de, "o_de");
        check_color('0, o_red, "o_red");
        check_color('0, o_green, "o_green");
        check_color('0, o_blue, "o_blue");
    endtask

    task automatic test_counting();
        repeat (3 * slow_div + 2) step();
        check_led(led_t'(3));
    endtask

    task automatic test_pause_clear();
        // pause, the value must hold for three tick periods
        press_key(0);
        repeat (3 * slow_div) step();
        check_led(led_t'(3));
        // resume from the held value
        press_key(0);
        wait_led_change(led_t'(3), 2 * slow_div);
        check_led(led_t'(4));
        repeat (slow_div) step();
        check_led(led_t'(5));
        press_key(1);
        check_led('0);
    endtask

    task automatic test_h_timing();
        apply_reset();
        for (int c = 0; c <= h_total; c++)
        begin
            check_bit(exp_de(c), o_de, "o_de");
            check_bit(exp_hsync(c), o_hsync, "o_hsync");
            step();
        end
    endtask

    task automatic test_colour();
        int x;
        int y;
        apply_reset();
        for (int c = 0; c < 2 * h_total; c++)
        begin
            x = c % h_total;
            y = c / h_total;
            check_bit(exp_de(c), o_de, "o_de");
            if (exp_de(c))
            begin
                check_color(color_t'(x % 256), o_red, "o_red");
                check_color(color_t'(y % 256), o_green, "o_green");
                check_color(color_t'(int'(exp_count(c)) * 4), o_blue, "o_blue");
            end
            else
            begin
                check_color('0, o_red, "o_red");
                check_color('0, o_green, "o_green");
                check_color('0, o_blue, "o_blue");
            end
            step();
        end
    endtask

    task automatic test_v_timing();
        apply_reset();
        for (int c = 0; c <= v_total * h_total; c++)
        begin
            check_bit(exp_vsync(c), o_vsync, "o_vsync");
            check_bit(exp_de(c), o_de, "o_de");
            step();
        end
    endtask

    //----------------------------------------------------------------------

    initial
    begin
        i_rst        = 1'b1;
        i_key        = '1;
        mismatches   = 0;
        other_errors = 0;

        apply_reset();
        test_reset_state();
        test_counting();
        test_pause_clear();
        test_h_timing();
        test_colour();
        test_v_timing();

        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if ((mismatches == 0) && (other_errors == 0))
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps

module vga_timing
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    output coord_t o_x,
    output coord_t o_y,
    output logic   o_de,
    output logic   o_hsync,
    output logic   o_vsync
);

    //----------------------------------------------------------------------
    // phase of one scan axis from its position

    function automatic scan_phase_t scan_phase
    (
        input coord_t pos,
        input int     len_active,
        input int     len_front,
        input int     len_sync
    );
        scan_phase_t phase;

        if (int'(pos) < len_active)
            phase = phase_active;
        else if (int'(pos) < len_active + len_front)
            phase = phase_front;
        else if (int'(pos) < len_active + len_front + len_sync)
            phase = phase_sync;
        else
            phase = phase_back;

        return phase;
    endfunction

    //----------------------------------------------------------------------
    // scan counters

    coord_t x;
    coord_t y;

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = (x == coord_t'(h_total - 1));
    assign y_wrap = (y == coord_t'(v_total - 1));

    // pixel rate is clk itself, one pixel per cycle
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            x <= '0;
        end
        else if (x_wrap)
        begin
            x <= '0;
        end
        else
        begin
            x <= x + 1'b1;
        end
    end

    // next line on every horizontal wrap
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            y <= '0;
        end
        else if (x_wrap)
        begin
            if (y_wrap)
                y <= '0;
            else
                y <= y + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // decode from the current counters

    scan_phase_t h_phase;
    scan_phase_t v_phase;

    assign h_phase = scan_phase(x, h_active, h_front, h_sync);
    assign v_phase = scan_phase(y, v_active, v_front, v_sync);

    assign o_de    = (h_phase == phase_active) && (v_phase == phase_active);

    // both syncs are active low
    assign o_hsync = (h_phase != phase_sync);
    assign o_vsync = (v_phase != phase_sync);

    assign o_x = x;
    assign o_y = y;

endmodule
